// ==== design/sdram_bus_pkg.sv ====
// ============================================================================
// Shared constants and types for the arcade SDRAM slot multiplexer
// Region offsets, bank mapping, slot address widths and arbiter states
// ============================================================================
package sdram_bus_pkg;

    // SDRAM port geometry, addresses count 16-bit words
    localparam int SDRAM_AW  = 22;
    localparam int SDRAM_DW  = 32;
    localparam int WR_DW     = 16;
    localparam int NUM_SLOTS = 4;

    // Region base offsets in SDRAM words
    localparam logic [SDRAM_AW-1:0] ROM_OFFSET   = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] RAM_OFFSET   = 22'h20_0000;
    localparam logic [SDRAM_AW-1:0] VRAM_OFFSET  = 22'h30_0000;
    localparam logic [SDRAM_AW-1:0] GFX_OFFSET   = 22'h00_0000;
    localparam logic [SDRAM_AW-1:0] SOUND_OFFSET = 22'h00_0000;

    // Bank per region
    localparam logic [1:0] ROM_BANK   = 2'd1;
    localparam logic [1:0] RAM_BANK   = 2'd0;
    localparam logic [1:0] GFX_BANK   = 2'd2;
    localparam logic [1:0] SOUND_BANK = 2'd0;

    // Client address widths
    // ROM and RAM are word addresses, GFX counts 32-bit words
    localparam int ROM_AW = 21;
    localparam int RAM_AW = 17;
    localparam int GFX_AW = 20;
    // Sound CPU sees bytes
    localparam int SND_AW = 16;

    // Arbiter sequencer
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_REQ  = 2'd1,
        ST_WAIT = 2'd2
    } arb_state_t;

    typedef logic [1:0] slot_idx_t;

endpackage

// ==== design/slot_if.sv ====
// ============================================================================
// One slot's request to the SDRAM arbiter and the read data coming back
// Slots use the requester modport, the arbiter the arbiter modport
// ============================================================================
`timescale 1ns/1ps

interface slot_if;
    import sdram_bus_pkg::*;

    // Request side, held stable while req is high
    logic                req;
    logic [SDRAM_AW-1:0] addr;
    logic                wr;
    logic [WR_DW-1:0]    wdata;
    logic [1:0]          wrmask;

    // Return side, rdata only meaningful with grant_ok
    logic                grant_ok;
    logic [SDRAM_DW-1:0] rdata;

    modport requester (
        output req, addr, wr, wdata, wrmask,
        input  grant_ok, rdata
    );

    modport arbiter (
        input  req, addr, wr, wdata, wrmask,
        output grant_ok, rdata
    );

endinterface

// ==== design/slot_request.sv ====
// ============================================================================
// Read-only SDRAM slot: latches a client request, maps it to an SDRAM word
// address and hands back 8, 16 or 32 bits of the returned word
// ============================================================================
`timescale 1ns/1ps

module slot_request #(
    parameter int                                  AW     = 16,
    parameter int                                  DW     = 16,
    parameter logic [sdram_bus_pkg::SDRAM_AW-1:0] OFFSET = '0,
    // 1 for 32-bit words, 0 for 16-bit words, -1 for byte addresses
    parameter int                                  SCALE  = 0
) (
    input  logic          VB,
    input  logic          arst_n,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic          ok,
    output logic [DW-1:0] dout,
    slot_if.requester     port
);
    import sdram_bus_pkg::*;

    logic                cs_last;
    logic                start;
    logic                byte_sel;
    logic [SDRAM_AW-1:0] word_addr;
    logic [DW-1:0]       rd_data;

    // New access on a cs edge; cs_last drops during ok so a held cs restarts
    assign start = cs && !cs_last && !port.req;

    generate
        if (SCALE > 0) begin : g_up
            assign word_addr = OFFSET + (SDRAM_AW'(addr) << SCALE);
        end else if (SCALE < 0) begin : g_byte
            assign word_addr = OFFSET + SDRAM_AW'(addr >> 1);
        end else begin : g_word
            assign word_addr = OFFSET + SDRAM_AW'(addr);
        end

        if (DW == 8) begin : g_dw8
            assign rd_data = byte_sel ? port.rdata[15:8] : port.rdata[7:0];
        end else if (DW == 16) begin : g_dw16
            assign rd_data = port.rdata[15:0];
        end else begin : g_dw32
            assign rd_data = port.rdata;
        end
    endgenerate

    // Never writes
    assign port.wr     = 1'b0;
    assign port.wdata  = '0;
    assign port.wrmask = 2'b11;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            cs_last  <= 1'b0;
            port.req <= 1'b0;
            ok       <= 1'b0;
        end else begin
            cs_last <= ok ? 1'b0 : cs;
            ok      <= port.grant_ok;
            if (port.grant_ok) begin
                port.req <= 1'b0;
            end else if (start) begin
                port.req <= 1'b1;
            end
        end
    end

    always_ff @(posedge VB) begin
        if (start) begin
            port.addr <= word_addr;
            byte_sel  <= addr[0];
        end
        if (port.grant_ok) begin
            dout <= rd_data;
        end
    end

    // Client keeps cs up until it has seen ok
    a_cs_held: assert property (@(posedge VB) disable iff (!arst_n)
        port.req |=> cs);

endmodule

// ==== design/ram_slot.sv ====
// ============================================================================
// Main CPU work RAM / video RAM slot with write data and byte mask
// Either chip select starts an access; ok also closes writes
// ============================================================================
`timescale 1ns/1ps

module ram_slot (
    input  logic                             VB,
    input  logic                             arst_n,
    input  logic                             ram_cs,
    input  logic                             vram_cs,
    input  logic                             rnw,
    input  logic [sdram_bus_pkg::RAM_AW-1:0] addr,
    input  logic [15:0]                      din,
    input  logic [1:0]                       dsn,
    output logic                             ok,
    output logic [15:0]                      dout,
    slot_if.requester                        port
);
    import sdram_bus_pkg::*;

    logic                cs_any;
    logic                cs_last;
    logic                start;
    logic [SDRAM_AW-1:0] region_base;

    assign cs_any = ram_cs || vram_cs;
    assign start  = cs_any && !cs_last && !port.req;

    // Work RAM or video RAM region
    assign region_base = ram_cs ? RAM_OFFSET : VRAM_OFFSET;

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            cs_last  <= 1'b0;
            port.req <= 1'b0;
            ok       <= 1'b0;
        end else begin
            cs_last <= ok ? 1'b0 : cs_any;
            ok      <= port.grant_ok;
            if (port.grant_ok) begin
                port.req <= 1'b0;
            end else if (start) begin
                port.req <= 1'b1;
            end
        end
    end

    // Request payload, stable for the whole access
    always_ff @(posedge VB) begin
        if (start) begin
            port.addr   <= region_base + SDRAM_AW'(addr);
            port.wr     <= !rnw;
            port.wdata  <= din;
            // dsn low enables that byte
            port.wrmask <= dsn;
        end
    end

    // Read data only, a write leaves dout as it was
    always_ff @(posedge VB) begin
        if (port.grant_ok && !port.wr) begin
            dout <= port.rdata[15:0];
        end
    end

    // CPU decoder selects one region at a time
    a_one_region: assert property (@(posedge VB) disable iff (!arst_n)
        !(ram_cs && vram_cs));

endmodule

// ==== design/slot_arbiter.sv ====
// ============================================================================
// Fixed-priority SDRAM arbiter: grants the lowest pending slot, runs the
// controller's req/ack/ready handshake and returns the word to that slot
// ============================================================================
`timescale 1ns/1ps

module slot_arbiter (
    input  logic                                 VB,
    input  logic                                 arst_n,
    slot_if.arbiter                              slots [sdram_bus_pkg::NUM_SLOTS],
    output logic                                 sdram_req,
    input  logic                                 sdram_ack,
    input  logic                                 data_rdy,
    input  logic [sdram_bus_pkg::SDRAM_DW-1:0]   data_read,
    output logic [sdram_bus_pkg::SDRAM_AW-1:0]   sdram_addr,
    output logic [1:0]                           sdram_bank,
    output logic                                 sdram_rnw,
    output logic [1:0]                           sdram_wrmask,
    output logic [sdram_bus_pkg::WR_DW-1:0]      data_write
);
    import sdram_bus_pkg::*;

    arb_state_t          state;
    slot_idx_t           winner;
    slot_idx_t           pick;
    logic                any_req;
    logic [1:0]          pick_bank;
    logic                grant_r;
    logic [SDRAM_DW-1:0] rdata_q;

    logic [NUM_SLOTS-1:0] req_v;
    logic [NUM_SLOTS-1:0] wr_v;
    logic [NUM_SLOTS-1:0] grant_v;
    logic [SDRAM_AW-1:0]  addr_v  [NUM_SLOTS];
    logic [WR_DW-1:0]     wdata_v [NUM_SLOTS];
    logic [1:0]           mask_v  [NUM_SLOTS];

    // Flatten the slot interfaces so they can be indexed by slot number
    generate
        for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
            assign req_v[g]   = slots[g].req;
            assign wr_v[g]    = slots[g].wr;
            assign addr_v[g]  = slots[g].addr;
            assign wdata_v[g] = slots[g].wdata;
            assign mask_v[g]  = slots[g].wrmask;

            assign grant_v[g]        = grant_r && (winner == slot_idx_t'(g));
            assign slots[g].grant_ok = grant_v[g];
            assign slots[g].rdata    = grant_v[g] ? rdata_q : '0;
        end
    endgenerate

    // Lowest slot number wins
    always_comb begin
        pick    = '0;
        any_req = 1'b0;
        for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
            if (req_v[i]) begin
                pick    = slot_idx_t'(i);
                any_req = 1'b1;
            end
        end
    end

    always_comb begin
        case (pick)
            2'd0:    pick_bank = ROM_BANK;
            2'd1:    pick_bank = RAM_BANK;
            2'd2:    pick_bank = GFX_BANK;
            default: pick_bank = SOUND_BANK;
        endcase
    end

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            winner    <= '0;
            sdram_req <= 1'b0;
            sdram_rnw <= 1'b1;
            grant_r   <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (any_req) begin
                        winner    <= pick;
                        sdram_req <= 1'b1;
                        sdram_rnw <= !wr_v[pick];
                        state     <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    // Stay here through grant_ok so the winner's req can drop
                    if (grant_r) begin
                        grant_r <= 1'b0;
                        state   <= ST_IDLE;
                    end else if (data_rdy) begin
                        grant_r <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Access payload, captured with the grant decision
    always_ff @(posedge VB) begin
        if (state == ST_IDLE && any_req) begin
            sdram_addr   <= addr_v[pick];
            sdram_bank   <= pick_bank;
            sdram_wrmask <= mask_v[pick];
            data_write   <= wdata_v[pick];
        end
        if (state == ST_WAIT && data_rdy && !grant_r) begin
            rdata_q <= data_read;
        end
    end

    // Controller sees a steady request until it acknowledges
    a_req_hold: assert property (@(posedge VB) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr));

    a_one_grant: assert property (@(posedge VB) disable iff (!arst_n)
        $onehot0(grant_v));

endmodule

// ==== design/game_sdram_bus.sv ====
// ============================================================================
// SDRAM sharing for the arcade core: four client slots and one arbiter
// in front of a single SDRAM controller port
// ============================================================================
`timescale 1ns/1ps

module game_sdram_bus (
    input  logic                               VB,
    input  logic                               arst_n,
    // Main CPU program ROM
    input  logic                               main_rom_cs,
    input  logic [sdram_bus_pkg::ROM_AW-1:0]   main_rom_addr,
    output logic                               main_rom_ok,
    output logic [15:0]                        main_rom_data,
    // Main CPU work RAM and video RAM
    input  logic                               main_ram_cs,
    input  logic                               main_vram_cs,
    input  logic                               main_rnw,
    input  logic [sdram_bus_pkg::RAM_AW-1:0]   ram_addr,
    input  logic [15:0]                        main_dout,
    input  logic [1:0]                         dsn,
    output logic                               main_ram_ok,
    output logic [15:0]                        main_ram_data,
    // Graphics ROM
    input  logic                               gfx_cs,
    input  logic [sdram_bus_pkg::GFX_AW-1:0]   gfx_addr,
    output logic                               gfx_ok,
    output logic [31:0]                        gfx_data,
    // Sound CPU ROM
    input  logic                               snd_cs,
    input  logic [sdram_bus_pkg::SND_AW-1:0]   snd_addr,
    output logic                               snd_ok,
    output logic [7:0]                         snd_data,
    // SDRAM controller
    output logic                               sdram_req,
    input  logic                               sdram_ack,
    input  logic                               data_rdy,
    input  logic [sdram_bus_pkg::SDRAM_DW-1:0] data_read,
    output logic [sdram_bus_pkg::SDRAM_AW-1:0] sdram_addr,
    output logic [1:0]                         sdram_bank,
    output logic                               sdram_rnw,
    output logic [1:0]                         sdram_wrmask,
    output logic [sdram_bus_pkg::WR_DW-1:0]    data_write
);
    import sdram_bus_pkg::*;

    // Slot number is the array index, which is also the priority
    slot_if bus [NUM_SLOTS] ();

    slot_request #(
        .AW     (ROM_AW),
        .DW     (16),
        .OFFSET (ROM_OFFSET),
        .SCALE  (0)
    ) u_rom_slot (
        .VB     (VB),
        .arst_n (arst_n),
        .cs     (main_rom_cs),
        .addr   (main_rom_addr),
        .ok     (main_rom_ok),
        .dout   (main_rom_data),
        .port   (bus[0])
    );

    ram_slot u_ram_slot (
        .VB      (VB),
        .arst_n  (arst_n),
        .ram_cs  (main_ram_cs),
        .vram_cs (main_vram_cs),
        .rnw     (main_rnw),
        .addr    (ram_addr),
        .din     (main_dout),
        .dsn     (dsn),
        .ok      (main_ram_ok),
        .dout    (main_ram_data),
        .port    (bus[1])
    );

    // 32-bit tiles, two SDRAM words each
    slot_request #(
        .AW     (GFX_AW),
        .DW     (32),
        .OFFSET (GFX_OFFSET),
        .SCALE  (1)
    ) u_gfx_slot (
        .VB     (VB),
        .arst_n (arst_n),
        .cs     (gfx_cs),
        .addr   (gfx_addr),
        .ok     (gfx_ok),
        .dout   (gfx_data),
        .port   (bus[2])
    );

    slot_request #(
        .AW     (SND_AW),
        .DW     (8),
        .OFFSET (SOUND_OFFSET),
        .SCALE  (-1)
    ) u_snd_slot (
        .VB     (VB),
        .arst_n (arst_n),
        .cs     (snd_cs),
        .addr   (snd_addr),
        .ok     (snd_ok),
        .dout   (snd_data),
        .port   (bus[3])
    );

    slot_arbiter u_arbiter (
        .VB           (VB),
        .arst_n       (arst_n),
        .slots        (bus),
        .sdram_req    (sdram_req),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .data_read    (data_read),
        .sdram_addr   (sdram_addr),
        .sdram_bank   (sdram_bank),
        .sdram_rnw    (sdram_rnw),
        .sdram_wrmask (sdram_wrmask),
        .data_write   (data_write)
    );

endmodule

// ==== sim/game_sdram_bus_tb.sv ====
// ============================================================================
// Testbench for the SDRAM slot multiplexer that replays sim/sdram_bus_patterns.txt
// against a behavioral SDRAM controller with random ack and ready delays
// ============================================================================
`timescale 1ns/1ps

module game_sdram_bus_tb;
    import sdram_bus_pkg::*;

    // Fields per pattern line and the most lines read
    localparam int NF      = 9;
    localparam int PAT_MAX = 64;

    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [1:0]          bank;
        logic                rnw;
        logic [1:0]          mask;
        logic [WR_DW-1:0]    wdata;
    } access_t;

    logic                VB;
    logic                arst_n;
    logic                main_rom_cs, main_ram_cs, main_vram_cs, main_rnw, gfx_cs, snd_cs;
    logic [ROM_AW-1:0]   main_rom_addr;
    logic [RAM_AW-1:0]   ram_addr;
    logic [GFX_AW-1:0]   gfx_addr;
    logic [SND_AW-1:0]   snd_addr;
    logic [15:0]         main_dout;
    logic [1:0]          dsn;
    logic                main_rom_ok, main_ram_ok, gfx_ok, snd_ok;
    logic [15:0]         main_rom_data, main_ram_data;
    logic [31:0]         gfx_data;
    logic [7:0]          snd_data;
    logic                sdram_req, sdram_ack, data_rdy, sdram_rnw;
    logic [SDRAM_DW-1:0] data_read;
    logic [SDRAM_AW-1:0] sdram_addr;
    logic [1:0]          sdram_bank, sdram_wrmask;
    logic [WR_DW-1:0]    data_write;

    logic [31:0] pat_words [PAT_MAX*NF];
    logic [31:0] mem [logic [23:0]];
    access_t     acc_log [$];
    logic [31:0] rng_state = 32'ha258;
    logic        pat_loaded = 1'b0;
    int          num_pat, hold_cycles, rdy_total, ok_total;
    int          err_count, test_err, check_count, test_count;
    int          ok_cnt [NUM_SLOTS];
    string       cur_test = "reset_state";
    string       test_names [8] = '{"rom_read", "ram_write_read", "vram_write_read",
                                    "snd_even", "snd_odd", "gfx_read", "all_four",
                                    "back_pressure"};

    game_sdram_bus u_dut (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // A nonzero hold overrides the random delay for the current group
    function automatic int next_delay();
        rng_state = xorshift32(rng_state);
        return (hold_cycles != 0) ? hold_cycles : int'(rng_state % 6);
    endfunction

    // Unwritten words return the address in the low half
    // and its inverse mixed with the bank and top address bits in the high half
    function automatic logic [31:0] fill_word(input logic [23:0] key);
        return {~key[15:0] ^ {8'h00, key[23:16]}, key[15:0]};
    endfunction

    function automatic logic [31:0] field(input int idx, input int f);
        return pat_words[idx*NF + f];
    endfunction

    // SDRAM word address from each slot's region offset and address scaling
    function automatic logic [SDRAM_AW-1:0] expect_addr(input int slot, input logic [31:0] op,
                                                       input logic [31:0] a);
        case (slot)
            0:       return ROM_OFFSET + a[ROM_AW-1:0];
            1:       return (op[1] ? VRAM_OFFSET : RAM_OFFSET) + a[RAM_AW-1:0];
            2:       return GFX_OFFSET + {a[GFX_AW-1:0], 1'b0};
            default: return SOUND_OFFSET + a[SND_AW-1:1];
        endcase
    endfunction

    function automatic logic [1:0] expect_bank(input int slot);
        case (slot)
            0:       return ROM_BANK;
            1:       return RAM_BANK;
            2:       return GFX_BANK;
            default: return SOUND_BANK;
        endcase
    endfunction

    function automatic logic ok_of(input int slot);
        case (slot)
            0:       return main_rom_ok;
            1:       return main_ram_ok;
            2:       return gfx_ok;
            default: return snd_ok;
        endcase
    endfunction

    function automatic logic [31:0] data_of(input int slot);
        case (slot)
            0:       return {16'h0, main_rom_data};
            1:       return {16'h0, main_ram_data};
            2:       return gfx_data;
            default: return {24'h0, snd_data};
        endcase
    endfunction

    task automatic check_value(input string what, input logic [31:0] expv,
                               input logic [31:0] got);
        check_count++;
        assert (got === expv) else begin
            $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, expv, got);
            err_count++;
            test_err++;
        end
    endtask

    task automatic note_failure(input string msg);
        $display("ERROR %s: %s", cur_test, msg);
        err_count++;
        test_err++;
    endtask

    task automatic close_test();
        test_count++;
        $display("%-16s %s, %0d error(s)", cur_test, (test_err == 0) ? "passed" : "failed",
                 test_err);
        test_err = 0;
    endtask

    task automatic drive_slot(input int slot, input logic [31:0] op, input logic [31:0] a,
                              input logic [31:0] wd, input logic [31:0] m, input logic on);
        case (slot)
            0: begin
                main_rom_cs   = on;
                main_rom_addr = a[ROM_AW-1:0];
            end
            1: begin
                main_ram_cs  = on && !op[1];
                main_vram_cs = on && op[1];
                main_rnw     = !op[0];
                ram_addr     = a[RAM_AW-1:0];
                main_dout    = wd[15:0];
                dsn          = m[1:0];
            end
            2: begin
                gfx_cs   = on;
                gfx_addr = a[GFX_AW-1:0];
            end
            default: begin
                snd_cs   = on;
                snd_addr = a[SND_AW-1:0];
            end
        endcase
    endtask

    initial begin
        VB = 1'b0;
        forever #4 VB = ~VB;
    end

    // SDRAM controller model serving one access at a time
    initial begin : sdram_model
        access_t     acc;
        logic [23:0] key;
        logic [31:0] word;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge VB);
            #1;
            if (arst_n && sdram_req) begin
                acc = {sdram_addr, sdram_bank, sdram_rnw, sdram_wrmask, data_write};
                repeat (next_delay()) begin
                    @(posedge VB);
                    #1;
                    assert (sdram_req && sdram_addr === acc.addr)
                        else note_failure("request dropped or address moved before ack");
                end
                sdram_ack = 1'b1;
                @(posedge VB);
                #1;
                sdram_ack = 1'b0;
                assert (!sdram_req) else note_failure("sdram_req still high after ack");
                key  = {acc.bank, acc.addr};
                word = mem.exists(key) ? mem[key] : fill_word(key);
                // dsn low writes that byte
                if (!acc.rnw) begin
                    if (!acc.mask[0])
                        word[7:0] = acc.wdata[7:0];
                    if (!acc.mask[1])
                        word[15:8] = acc.wdata[15:8];
                    mem[key] = word;
                end
                acc_log.push_back(acc);
                repeat (next_delay()) begin
                    @(posedge VB);
                    #1;
                end
                data_read = word;
                data_rdy  = 1'b1;
                rdy_total++;
                @(posedge VB);
                #1;
                data_rdy  = 1'b0;
                data_read = '0;
            end
        end
    end

    // ok sampled on the falling edge where it is stable
    always @(negedge VB) begin
        if (arst_n) begin
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (ok_of(s)) begin
                    ok_cnt[s]++;
                    ok_total++;
                end
            end
            assert (ok_total <= rdy_total) else note_failure("ok pulsed before its data_rdy");
        end
    end

    initial begin
        wait (pat_loaded);
        repeat (num_pat * 20) @(posedge VB);
        $display("ERROR watchdog: run exceeded %0d cycles", num_pat * 20);
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main_seq
        int                   first, last, slot, hold, cycles, name_idx;
        int                   ok_base [NUM_SLOTS];
        logic [31:0]          grp, op;
        logic [NUM_SLOTS-1:0] pending, dropping;
        access_t              acc;
        arst_n = 1'b0;
        drive_slot(0, 0, 0, 0, 3, 1'b0);
        drive_slot(1, 0, 0, 0, 3, 1'b0);
        drive_slot(2, 0, 0, 0, 3, 1'b0);
        drive_slot(3, 0, 0, 0, 3, 1'b0);
        // All ones marks the words past the last pattern line
        foreach (pat_words[i])
            pat_words[i] = '1;
        $readmemh("sim/sdram_bus_patterns.txt", pat_words);
        while (num_pat < PAT_MAX && field(num_pat, 0) !== '1)
            num_pat++;
        pat_loaded = (num_pat > 0);
        repeat (3) @(posedge VB);
        #1;
        arst_n = 1'b1;
        @(posedge VB);
        #1;
        check_value("sdram_req", 0, sdram_req);
        check_value("sdram_rnw", 1, sdram_rnw);
        check_value("ok outputs", 0, {main_rom_ok, main_ram_ok, gfx_ok, snd_ok});
        close_test();
        if (num_pat == 0)
            note_failure("no patterns read from the pattern file");

        first    = 0;
        name_idx = -1;
        while (first < num_pat) begin
            // Consecutive lines with the same nonzero group start together
            grp  = field(first, 1);
            last = first;
            while (grp != 0 && last + 1 < num_pat && field(last + 1, 1) == grp)
                last++;
            if (field(first, 0) != name_idx) begin
                if (name_idx >= 0)
                    close_test();
                name_idx = field(first, 0);
                cur_test = test_names[name_idx];
            end
            hold    = 0;
            pending = '0;
            for (int k = first; k <= last; k++) begin
                hold = (field(k, 7) > hold) ? field(k, 7) : hold;
                pending[field(k, 2)] = 1'b1;
            end
            for (int s = 0; s < NUM_SLOTS; s++)
                ok_base[s] = ok_cnt[s];
            hold_cycles = hold;
            dropping    = '0;
            cycles      = 0;
            @(posedge VB);
            #1;
            for (int k = first; k <= last; k++)
                drive_slot(field(k, 2), field(k, 3), field(k, 4), field(k, 5), field(k, 6), 1'b1);

            // cs is held one cycle past ok and then dropped
            while ((pending | dropping) != 0 && cycles < 200) begin
                @(posedge VB);
                #1;
                cycles++;
                for (int k = first; k <= last; k++) begin
                    slot = field(k, 2);
                    op   = field(k, 3);
                    if (dropping[slot]) begin
                        drive_slot(slot, op, field(k, 4), field(k, 5), field(k, 6), 1'b0);
                        dropping[slot] = 1'b0;
                    end else if (pending[slot] && ok_of(slot)) begin
                        if (!op[0])
                            check_value("read data", field(k, 8), data_of(slot));
                        pending[slot]  = 1'b0;
                        dropping[slot] = 1'b1;
                    end
                end
            end
            assert (pending == 0) else note_failure("a slot gave no ok within 200 cycles");
            for (int k = first; k <= last; k++)
                drive_slot(field(k, 2), field(k, 3), field(k, 4), field(k, 5), field(k, 6), 1'b0);
            repeat (2) @(posedge VB);
            #1;

            // SDRAM accesses must follow the line order that lists slots in order
            for (int k = first; k <= last; k++) begin
                slot = field(k, 2);
                op   = field(k, 3);
                check_value("ok pulse count", 1, ok_cnt[slot] - ok_base[slot]);
                if (acc_log.size() == 0) begin
                    note_failure("SDRAM access missing");
                end else begin
                    acc = acc_log.pop_front();
                    check_value("sdram_addr", expect_addr(slot, op, field(k, 4)), acc.addr);
                    check_value("sdram_bank", expect_bank(slot), acc.bank);
                    check_value("sdram_rnw", !op[0], acc.rnw);
                    if (op[0]) begin
                        check_value("sdram_wrmask", field(k, 6), acc.mask);
                        check_value("data_write", field(k, 5), acc.wdata);
                    end
                end
            end
            assert (acc_log.size() == 0) else note_failure("extra SDRAM accesses in the group");
            acc_log.delete();
            first = last + 1;
        end
        if (name_idx >= 0)
            close_test();

        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== sim/sdram_bus_patterns.txt ====
// name group slot op addr wdata mask hold expect, all hex
// op bit 0 write, bit 1 video RAM; group 0 runs alone; hold 0 gives random delays
// rom_read
0 0 0 0 001234 0000 3 0 00001234
0 0 0 0 1ABCDE 0000 3 0 0000BCDE
// ram_write_read
1 0 1 1 0A5A0 BEEF 0 0 00000000
1 0 1 0 0A5A0 0000 3 0 0000BEEF
1 0 1 1 0A5A0 1177 2 0 00000000
1 0 1 0 0A5A0 0000 3 0 0000BE77
// vram_write_read, same ram_addr lands in its own region
2 0 1 2 0A5A0 0000 3 0 0000A5A0
2 0 1 3 0A5A0 5AC3 1 0 00000000
2 0 1 2 0A5A0 0000 3 0 00005AA0
2 0 1 0 0A5A0 0000 3 0 0000BE77
// snd_even
3 0 3 0 2468 0000 3 0 00000034
3 0 3 0 1FFE 0000 3 0 000000FF
// snd_odd
4 0 3 0 2469 0000 3 0 00000012
4 0 3 0 FFFF 0000 3 0 0000007F
// gfx_read
5 0 2 0 8ACE1 0000 3 0 A6AC59C2
5 0 2 0 00010 0000 3 0 FF5F0020
// all_four, each group raises its cs lines in one cycle
6 1 0 0 000777 0000 3 0 00000777
6 1 1 0 0A5A0 0000 3 0 0000BE77
6 1 2 0 00100 0000 3 0 FD7F0200
6 1 3 0 4321 0000 3 0 00000021
6 2 0 0 000100 0000 3 0 00000100
6 2 1 3 00042 CAFE 0 0 00000000
6 2 2 0 00042 0000 3 0 FFFB0084
6 2 3 0 0100 0000 3 0 00000080
6 0 1 2 00042 0000 3 0 0000CAFE
// back_pressure, ack and data_rdy held off for 6 cycles
7 3 0 0 000ABC 0000 3 6 00000ABC
7 3 1 1 1FFFF 0F0F 0 6 00000000
7 3 2 0 00001 0000 3 6 FF7D0002
7 0 1 0 1FFFF 0000 3 6 00000F0F

// ==== game_sdram_bus.f ====
design/sdram_bus_pkg.sv
design/slot_if.sv
design/slot_request.sv
design/ram_slot.sv
design/slot_arbiter.sv
design/game_sdram_bus.sv
sim/game_sdram_bus_tb.sv
